//--- include/zhx_defs.svh
`ifndef ZHX_DEFS_SVH
`define ZHX_DEFS_SVH

// Datapath width, shared by data and instructions
`define ZHX_WORD_W 16

// Program RAM, 256 words, PC wraps with it
`define ZHX_RAM_AW 8
`define ZHX_RAM_DEPTH (1 << `ZHX_RAM_AW)

// Flash read port and boot image size
`define ZHX_FLASH_AW 16
`define ZHX_BOOT_WORDS 64

// APB register map, byte offsets
`define ZHX_APB_AW 8
`define ZHX_REG_CTRL 8'h00
`define ZHX_REG_STATUS 8'h04
`define ZHX_REG_PC 8'h08
`define ZHX_REG_GPR0 8'h20

`endif

//--- design/zhx_pkg.sv
`include "zhx_defs.svh"

package zhx_pkg;

	typedef logic [`ZHX_WORD_W-1:0] word_t;
	typedef logic [`ZHX_RAM_AW-1:0] ram_addr_t;
	typedef logic [2:0] reg_idx_t;

	// Instruction bits 15:12, codes 12 to 15 are illegal
	typedef enum logic [3:0] {
		OP_LI   = 4'd0,
		OP_ADDI = 4'd1,
		OP_ADD  = 4'd2,
		OP_SUB  = 4'd3,
		OP_AND  = 4'd4,
		OP_OR   = 4'd5,
		OP_SLL  = 4'd6,
		OP_LW   = 4'd7,
		OP_SW   = 4'd8,
		OP_BEQZ = 4'd9,
		OP_B    = 4'd10,
		OP_HALT = 4'd11
	} opcode_e;

	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		EXEC,
		MEM,
		HALTED
	} core_state_e;

	typedef enum logic [1:0] {
		REQ,
		WAIT,
		WRITE,
		DONE
	} boot_state_e;

endpackage

//--- design/zhx_ifs.sv
interface zhx_mem_if;
	import zhx_pkg::*;

	logic sel;
	logic we;
	ram_addr_t addr;
	word_t wdata;
	// Valid one edge after sel
	word_t rdata;

	modport requester (
		output sel,
		output we,
		output addr,
		output wdata,
		input rdata
	);

	modport memory (
		input sel,
		input we,
		input addr,
		input wdata,
		output rdata
	);
endinterface

interface zhx_dbg_if;
	import zhx_pkg::*;

	logic run;
	logic boot_done;
	logic halted;
	logic illegal;
	ram_addr_t pc;
	reg_idx_t reg_sel;
	word_t reg_value;

	modport regs (output run, output reg_sel,
		input boot_done, input halted, input illegal, input pc, input reg_value);

	modport core (input run, input reg_sel,
		output halted, output illegal, output pc, output reg_value);
endinterface

//--- design/boot_loader.sv
`include "zhx_defs.svh"

module boot_loader (
	input logic clk,
	input logic rst_n,
	output logic flash_rd,
	output logic [`ZHX_FLASH_AW-1:0] flash_addr,
	input zhx_pkg::word_t flash_data,
	input logic flash_ready,
	output logic boot_done,
	zhx_mem_if.requester ram
);
	import zhx_pkg::*;

	boot_state_e state;
	ram_addr_t cnt;
	word_t data_q;
	logic last_word;

	assign last_word = (cnt == ram_addr_t'(`ZHX_BOOT_WORDS - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= REQ;
			cnt <= '0;
		end else begin
			case (state)
				REQ: state <= WAIT;
				WAIT: begin
					if (flash_ready)
						state <= WRITE;
				end
				WRITE: begin
					if (last_word) begin
						state <= DONE;
					end else begin
						cnt <= cnt + ram_addr_t'(1);
						state <= REQ;
					end
				end
				default: state <= DONE;
			endcase
		end
	end

	// Flash word is captured in the cycle ready is seen
	always_ff @(posedge clk) begin
		if (state == WAIT && flash_ready)
			data_q <= flash_data;
	end

	// Request held through WAIT until the flash answers
	assign flash_rd = (state == WAIT);
	assign flash_addr = {{(`ZHX_FLASH_AW - `ZHX_RAM_AW){1'b0}}, cnt};
	assign boot_done = (state == DONE);

	assign ram.sel = (state == WRITE);
	assign ram.we = (state == WRITE);
	assign ram.addr = cnt;
	assign ram.wdata = data_q;

endmodule

//--- design/program_ram.sv
`include "zhx_defs.svh"

module program_ram (
	input logic clk,
	input logic boot_done,
	zhx_mem_if.memory boot,
	zhx_mem_if.memory core
);
	import zhx_pkg::*;

	word_t mem_q [`ZHX_RAM_DEPTH];
	word_t rdata_q;

	logic sel;
	logic we;
	ram_addr_t addr;
	word_t wdata;

	// Boot loader owns the port until the image is in
	assign sel = boot_done ? core.sel : boot.sel;
	assign we = boot_done ? core.we : boot.we;
	assign addr = boot_done ? core.addr : boot.addr;
	assign wdata = boot_done ? core.wdata : boot.wdata;

	always_ff @(posedge clk) begin
		if (sel) begin
			if (we)
				mem_q[addr] <= wdata;
			rdata_q <= mem_q[addr];
		end
	end

	// Both ports see the same read register
	assign boot.rdata = rdata_q;
	assign core.rdata = rdata_q;

endmodule

//--- design/cpu_core.sv
module cpu_core (
	input logic clk,
	input logic rst_n,
	input logic boot_done,
	zhx_mem_if.requester mem,
	zhx_dbg_if.core dbg
);
	import zhx_pkg::*;

	core_state_e state;
	ram_addr_t pc;
	word_t ir;
	word_t gpr [8];
	logic halted_q;
	logic illegal_q;

	opcode_e op;
	reg_idx_t rd;
	reg_idx_t rs;
	reg_idx_t rt;
	word_t rd_val;
	word_t rs_val;
	word_t rt_val;
	word_t alu_res;
	word_t ea;
	ram_addr_t pc_inc;
	ram_addr_t pc_next;
	logic alu_wr;
	logic is_mem;
	logic is_stop;
	logic bad_op;
	logic go;

	// Instruction fields
	assign op = opcode_e'(ir[15:12]);
	assign rd = ir[11:9];
	assign rs = ir[8:6];
	assign rt = ir[5:3];

	assign rd_val = gpr[rd];
	assign rs_val = gpr[rs];
	assign rt_val = gpr[rt];

	assign go = boot_done && dbg.run;
	assign pc_inc = pc + ram_addr_t'(1);
	assign ea = rs_val + {{11{ir[4]}}, ir[4:0]};

	always_comb begin
		alu_res = '0;
		alu_wr = 1'b0;
		is_mem = 1'b0;
		is_stop = 1'b0;
		bad_op = 1'b0;
		pc_next = pc_inc;
		case (op)
			OP_LI: begin
				alu_res = {8'h00, ir[7:0]};
				alu_wr = 1'b1;
			end
			OP_ADDI: begin
				alu_res = rd_val + {{8{ir[7]}}, ir[7:0]};
				alu_wr = 1'b1;
			end
			OP_ADD: begin
				alu_res = rs_val + rt_val;
				alu_wr = 1'b1;
			end
			OP_SUB: begin
				alu_res = rs_val - rt_val;
				alu_wr = 1'b1;
			end
			OP_AND: begin
				alu_res = rs_val & rt_val;
				alu_wr = 1'b1;
			end
			OP_OR: begin
				alu_res = rs_val | rt_val;
				alu_wr = 1'b1;
			end
			OP_SLL: begin
				alu_res = rs_val << ir[3:0];
				alu_wr = 1'b1;
			end
			OP_LW, OP_SW: is_mem = 1'b1;
			// Offsets wrap with the 8-bit PC
			OP_BEQZ: begin
				if (rd_val == '0)
					pc_next = pc_inc + ram_addr_t'(ir[7:0]);
			end
			OP_B: pc_next = pc_inc + ram_addr_t'(ir[10:0]);
			OP_HALT: is_stop = 1'b1;
			default: begin
				is_stop = 1'b1;
				bad_op = 1'b1;
			end
		endcase
	end

	// Fetch and load/store share the one RAM port
	always_comb begin
		mem.sel = 1'b0;
		mem.we = 1'b0;
		mem.addr = pc;
		mem.wdata = rd_val;
		if (state == FETCH) begin
			mem.sel = go;
		end else if (state == EXEC && is_mem) begin
			mem.sel = 1'b1;
			mem.we = (op == OP_SW);
			mem.addr = ram_addr_t'(ea);
		end
	end

	always_ff @(posedge clk) begin
		if (state == DECODE)
			ir <= mem.rdata;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= FETCH;
			pc <= '0;
			halted_q <= 1'b0;
			illegal_q <= 1'b0;
			for (int i = 0; i < 8; i++)
				gpr[i] <= '0;
		end else begin
			case (state)
				FETCH: begin
					if (go)
						state <= DECODE;
				end
				DECODE: state <= EXEC;
				EXEC: begin
					if (is_stop) begin
						// PC stays on the halting instruction
						state <= HALTED;
						halted_q <= 1'b1;
						illegal_q <= bad_op;
					end else begin
						pc <= pc_next;
						if (alu_wr)
							gpr[rd] <= alu_res;
						state <= is_mem ? MEM : FETCH;
					end
				end
				MEM: begin
					if (op == OP_LW)
						gpr[rd] <= mem.rdata;
					state <= FETCH;
				end
				default: state <= HALTED;
			endcase
		end
	end

	assign dbg.halted = halted_q;
	assign dbg.illegal = illegal_q;
	assign dbg.pc = pc;
	assign dbg.reg_value = gpr[dbg.reg_sel];

endmodule

//--- design/debug_regs.sv
`include "zhx_defs.svh"

module debug_regs (
	input logic clk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`ZHX_APB_AW-1:0] paddr,
	input zhx_pkg::word_t pwdata,
	output zhx_pkg::word_t prdata,
	output logic pready,
	output logic pslverr,
	zhx_dbg_if.regs dbg
);
	import zhx_pkg::*;

	logic run_q;
	logic access;
	logic is_ctrl;
	logic is_status;
	logic is_pc;
	logic is_gpr;
	logic mapped;

	assign access = psel && penable;

	assign is_ctrl = (paddr == `ZHX_REG_CTRL);
	assign is_status = (paddr == `ZHX_REG_STATUS);
	assign is_pc = (paddr == `ZHX_REG_PC);
	// Eight GPRs from 0x20 to 0x3c, word aligned
	assign is_gpr = ((paddr & 8'he3) == `ZHX_REG_GPR0);
	assign mapped = is_ctrl || is_status || is_pc || is_gpr;

	// No wait states
	assign pready = 1'b1;
	// Only CTRL takes writes
	assign pslverr = access && (!mapped || (pwrite && !is_ctrl));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			run_q <= 1'b0;
		else if (access && pwrite && is_ctrl)
			run_q <= pwdata[0];
	end

	assign dbg.run = run_q;
	assign dbg.reg_sel = paddr[4:2];

	always_comb begin
		prdata = '0;
		if (is_ctrl)
			prdata = word_t'(run_q);
		else if (is_status)
			prdata = word_t'({dbg.illegal, dbg.halted, dbg.boot_done});
		else if (is_pc)
			prdata = word_t'(dbg.pc);
		else if (is_gpr)
			prdata = dbg.reg_value;
	end

endmodule

//--- design/zhx_top.sv
`include "zhx_defs.svh"

module zhx_top (
	input logic clk,
	input logic rst_n,

	output logic flash_rd,
	output logic [`ZHX_FLASH_AW-1:0] flash_addr,
	input zhx_pkg::word_t flash_data,
	input logic flash_ready,

	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`ZHX_APB_AW-1:0] paddr,
	input zhx_pkg::word_t pwdata,
	output zhx_pkg::word_t prdata,
	output logic pready,
	output logic pslverr
);

	logic boot_done;

	zhx_mem_if boot_mem ();
	zhx_mem_if core_mem ();
	zhx_dbg_if dbg ();

	assign dbg.boot_done = boot_done;

	// Copies the flash image into RAM after reset
	boot_loader boot_i (
		.clk(clk),
		.rst_n(rst_n),
		.flash_rd(flash_rd),
		.flash_addr(flash_addr),
		.flash_data(flash_data),
		.flash_ready(flash_ready),
		.boot_done(boot_done),
		.ram(boot_mem)
	);

	program_ram ram_i (
		.clk(clk),
		.boot_done(boot_done),
		.boot(boot_mem),
		.core(core_mem)
	);

	cpu_core core_i (
		.clk(clk),
		.rst_n(rst_n),
		.boot_done(boot_done),
		.mem(core_mem),
		.dbg(dbg)
	);

	debug_regs regs_i (
		.clk(clk),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.dbg(dbg)
	);

endmodule

//--- verification/tb_checker.sv
module tb_checker (
	input logic clk,
	input logic rst_n,
	input logic flash_rd,
	input logic [15:0] flash_addr,
	input logic flash_ready,
	input logic psel,
	input logic penable,
	input logic [15:0] prdata,
	input logic pready,
	input logic pslverr
);
	timeunit 1ns;
	timeprecision 100ps;

	int checks = 0;
	int errors = 0;
	int test_errs = 0;
	int tests = 0;
	int tests_passed = 0;

	int req_count = 0;
	logic [15:0] next_addr = '0;
	logic prev_rd = 1'b0;
	logic prev_ready = 1'b0;
	logic [15:0] prev_addr = '0;

	// Expectation for the next APB access phase
	logic armed = 1'b0;
	logic check_data = 1'b0;
	logic exp_err = 1'b0;
	logic [15:0] exp_data = '0;
	string exp_name = "";

	task automatic fail_value(input string sig, input logic [15:0] got, input logic [15:0] exp);
		$display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, sig, got, exp);
		errors++;
		test_errs++;
	endtask

	task automatic expect_apb(input string name, input logic chk_data, input logic [15:0] data,
		input logic err);
		exp_name = name;
		check_data = chk_data;
		exp_data = data;
		exp_err = err;
		armed = 1'b1;
	endtask

	task automatic check_boot_count();
		checks++;
		if (req_count != 64)
			fail_value("flash request count", 16'(req_count), 16'd64);
	endtask

	task automatic end_test(input string name);
		tests++;
		if (test_errs == 0) begin
			tests_passed++;
			$display("Test %s: PASS", name);
		end else begin
			$display("Test %s: FAIL with %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	task automatic report_summary(output int fails);
		$display("Tests passed %0d of %0d, checks %0d, errors %0d",
			tests_passed, tests, checks, errors);
		fails = errors;
	endtask

	// APB access phase compare
	always @(posedge clk) begin
		if (psel && penable && armed) begin
			armed = 1'b0;
			checks++;
			if (pready !== 1'b1)
				fail_value($sformatf("pready (%s)", exp_name), 16'(pready), 16'd1);
			if (pslverr !== exp_err)
				fail_value($sformatf("pslverr (%s)", exp_name), 16'(pslverr), 16'(exp_err));
			if (check_data && prdata !== exp_data)
				fail_value($sformatf("prdata (%s)", exp_name), prdata, exp_data);
		end
	end

	// Flash requests must come in order and hold until ready
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_count = 0;
			next_addr = '0;
			prev_rd = 1'b0;
			prev_ready = 1'b0;
			prev_addr = '0;
		end else begin
			if (prev_rd && !prev_ready) begin
				checks++;
				if (flash_rd !== 1'b1)
					fail_value("flash_rd held", 16'(flash_rd), 16'd1);
				if (flash_addr !== prev_addr)
					fail_value("flash_addr held", flash_addr, prev_addr);
			end else if (flash_rd && !prev_rd) begin
				checks++;
				if (flash_addr !== next_addr)
					fail_value("flash_addr", flash_addr, next_addr);
				next_addr = next_addr + 16'd1;
				req_count++;
			end
			prev_rd = flash_rd;
			prev_ready = flash_ready;
			prev_addr = flash_addr;
		end
	end

endmodule

//--- verification/tb_top.sv
module tb_top;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [3:0] LI = 4'd0;
	localparam logic [3:0] ADDI = 4'd1;
	localparam logic [3:0] ADD = 4'd2;
	localparam logic [3:0] SUB = 4'd3;
	localparam logic [3:0] AND_OP = 4'd4;
	localparam logic [3:0] OR_OP = 4'd5;
	localparam logic [3:0] LW = 4'd7;
	localparam logic [3:0] SW = 4'd8;
	localparam logic [3:0] BEQZ = 4'd9;
	localparam logic [3:0] HALT = 4'd11;
	localparam int POLL_LIMIT = 2000;

	logic clk;
	logic rst_n;
	logic flash_rd;
	logic [15:0] flash_addr;
	logic [15:0] flash_data;
	logic flash_ready;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [15:0] pwdata;
	logic [15:0] prdata;
	logic pready;
	logic pslverr;

	logic [15:0] image [64];
	int unsigned lat;
	logic [15:0] exp_regs [8];
	logic [7:0] exp_pc;
	logic exp_ill;
	logic [15:0] rd_data;
	logic rd_err;
	int fails;

	zhx_top dut_i (.*);

	tb_checker chk_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Flash model with 0 to 5 cycles of latency per word
	always @(negedge clk) begin
		if (!rst_n) begin
			flash_ready = 1'b0;
			lat = $urandom % 6;
		end else if (flash_rd && !flash_ready) begin
			if (lat == 0) begin
				flash_ready = 1'b1;
				flash_data = image[flash_addr[5:0]];
			end else begin
				lat--;
			end
		end else if (!flash_rd) begin
			flash_ready = 1'b0;
			lat = $urandom % 6;
		end
	end

	function automatic logic [15:0] enc_i(logic [3:0] op, logic [2:0] rd, logic [7:0] imm);
		return {op, rd, 1'b0, imm};
	endfunction

	function automatic logic [15:0] enc_r(logic [3:0] op, logic [2:0] rd, logic [2:0] rs,
		logic [2:0] rt);
		return {op, rd, rs, rt, 3'b000};
	endfunction

	function automatic logic [15:0] enc_m(logic [3:0] op, logic [2:0] rd, logic [2:0] rs,
		logic [4:0] imm);
		return {op, rd, rs, 1'b0, imm};
	endfunction

	// Instruction set model, run until HALT or an illegal opcode
	function automatic void iss_run(input logic [15:0] img [64], output logic [15:0] regs [8],
		output logic [7:0] hpc, output logic ill);
		logic [15:0] m [256];
		logic [15:0] ir;
		logic [15:0] a;
		logic [15:0] b;
		logic [7:0] pc;
		logic [7:0] next;
		logic [7:0] ea;
		logic [2:0] rd;
		logic done;
		for (int i = 0; i < 256; i++)
			m[i] = (i < 64) ? img[i] : 16'h0000;
		for (int i = 0; i < 8; i++)
			regs[i] = 16'h0000;
		pc = 8'h00;
		hpc = 8'h00;
		ill = 1'b0;
		done = 1'b0;
		for (int step = 0; step < 10000 && !done; step++) begin
			ir = m[pc];
			rd = ir[11:9];
			a = regs[ir[8:6]];
			b = regs[ir[5:3]];
			ea = 8'(a + {{11{ir[4]}}, ir[4:0]});
			next = pc + 8'd1;
			case (ir[15:12])
				4'd0: regs[rd] = {8'h00, ir[7:0]};
				4'd1: regs[rd] = regs[rd] + {{8{ir[7]}}, ir[7:0]};
				4'd2: regs[rd] = a + b;
				4'd3: regs[rd] = a - b;
				4'd4: regs[rd] = a & b;
				4'd5: regs[rd] = a | b;
				4'd6: regs[rd] = a << ir[3:0];
				4'd7: regs[rd] = m[ea];
				4'd8: m[ea] = regs[rd];
				4'd9: if (regs[rd] == 16'h0000) next = pc + 8'd1 + ir[7:0];
				4'd10: next = pc + 8'd1 + ir[7:0];
				4'd11: done = 1'b1;
				default: begin
					done = 1'b1;
					ill = 1'b1;
				end
			endcase
			if (done)
				hpc = pc;
			else
				pc = next;
		end
	endfunction

	task automatic fill_image();
		for (int k = 0; k < 64; k++)
			image[k] = {HALT, 6'b000000, 6'(k)};
	endtask

	task automatic timeout_fail(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Simulation failed");
		$finish;
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
	endtask

	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [15:0] wdata,
		output logic [15:0] rdata, output logic err);
		int waited;
		waited = 0;
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		forever begin
			@(posedge clk);
			waited++;
			if (pready)
				break;
			if (waited > 16)
				timeout_fail("APB pready");
		end
		rdata = prdata;
		err = pslverr;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic poll_status(input int bit_idx, input string what);
		int tries;
		tries = 0;
		forever begin
			apb_xfer(1'b0, 8'h04, 16'h0000, rd_data, rd_err);
			if (rd_data[bit_idx])
				break;
			tries++;
			if (tries > POLL_LIMIT)
				timeout_fail(what);
		end
	endtask

	task automatic checked_xfer(input string name, input logic wr, input logic [7:0] addr,
		input logic [15:0] wdata, input logic chk_data, input logic [15:0] exp_data,
		input logic exp_err);
		chk_i.expect_apb(name, chk_data, exp_data, exp_err);
		apb_xfer(wr, addr, wdata, rd_data, rd_err);
	endtask

	initial begin
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'h00;
		pwdata = 16'h0000;
		flash_data = 16'h0000;
		flash_ready = 1'b0;
		void'($urandom(32'h5172_1f39));

		// Every opcode, LW after SW, a backward loop and forward branches
		fill_image();
		image[0] = enc_i(LI, 3'd1, 8'd5);
		image[1] = enc_i(LI, 3'd2, 8'd3);
		image[2] = enc_r(ADD, 3'd3, 3'd1, 3'd2);
		image[3] = enc_r(SUB, 3'd4, 3'd1, 3'd2);
		image[4] = enc_r(AND_OP, 3'd5, 3'd1, 3'd2);
		image[5] = enc_r(OR_OP, 3'd6, 3'd1, 3'd2);
		image[6] = {4'd6, 3'd7, 3'd1, 2'b00, 4'd4};
		image[7] = enc_i(ADDI, 3'd2, 8'hff);
		image[8] = enc_m(SW, 3'd3, 3'd7, 5'h1e);
		image[9] = enc_m(LW, 3'd4, 3'd7, 5'h1e);
		image[10] = enc_i(ADDI, 3'd1, 8'd1);
		image[11] = enc_i(ADDI, 3'd2, 8'hff);
		image[12] = enc_i(BEQZ, 3'd2, 8'd1);
		image[13] = {4'd10, 1'b0, 11'h7fc};
		image[14] = enc_i(BEQZ, 3'd1, 8'd1);
		image[15] = enc_i(LI, 3'd0, 8'h77);
		image[16] = {HALT, 12'h000};
		iss_run(image, exp_regs, exp_pc, exp_ill);

		apply_reset();
		checked_xfer("CTRL after reset", 1'b0, 8'h00, 16'h0, 1'b1, 16'h0000, 1'b0);
		checked_xfer("PC after reset", 1'b0, 8'h08, 16'h0, 1'b1, 16'h0000, 1'b0);
		checked_xfer("STATUS before boot", 1'b0, 8'h04, 16'h0, 1'b1, 16'h0000, 1'b0);
		chk_i.end_test("reset values");

		poll_status(0, "boot_done");
		chk_i.check_boot_count();
		chk_i.end_test("boot copy");

		checked_xfer("CTRL run", 1'b1, 8'h00, 16'h0001, 1'b0, 16'h0, 1'b0);
		poll_status(1, "halted");
		checked_xfer("PC at halt", 1'b0, 8'h08, 16'h0, 1'b1, {8'h00, exp_pc}, 1'b0);
		for (int n = 0; n < 8; n++)
			checked_xfer($sformatf("GPR%0d", n), 1'b0, 8'h20 + 8'(4 * n), 16'h0, 1'b1,
				exp_regs[n], 1'b0);
		checked_xfer("STATUS at halt", 1'b0, 8'h04, 16'h0, 1'b1, 16'h0003, 1'b0);
		chk_i.end_test("program run");

		// Second image stops on opcode 12
		fill_image();
		image[0] = enc_i(LI, 3'd1, 8'd9);
		image[1] = enc_r(ADD, 3'd2, 3'd1, 3'd1);
		image[2] = 16'hc000;
		image[3] = {HALT, 12'h000};
		iss_run(image, exp_regs, exp_pc, exp_ill);

		apply_reset();
		poll_status(0, "boot_done after second reset");
		chk_i.check_boot_count();
		checked_xfer("CTRL run", 1'b1, 8'h00, 16'h0001, 1'b0, 16'h0, 1'b0);
		poll_status(1, "halted on illegal opcode");
		checked_xfer("STATUS illegal", 1'b0, 8'h04, 16'h0, 1'b1, {13'h0, exp_ill, 2'b11}, 1'b0);
		checked_xfer("PC at illegal", 1'b0, 8'h08, 16'h0, 1'b1, {8'h00, exp_pc}, 1'b0);
		checked_xfer("GPR2", 1'b0, 8'h28, 16'h0, 1'b1, exp_regs[2], 1'b0);
		chk_i.end_test("illegal opcode");

		checked_xfer("STATUS write", 1'b1, 8'h04, 16'h0000, 1'b0, 16'h0, 1'b1);
		checked_xfer("unmapped read", 1'b0, 8'h10, 16'h0, 1'b1, 16'h0000, 1'b1);
		checked_xfer("unmapped write", 1'b1, 8'h40, 16'h0000, 1'b0, 16'h0, 1'b1);
		checked_xfer("CTRL kept", 1'b0, 8'h00, 16'h0, 1'b1, 16'h0001, 1'b0);
		chk_i.end_test("slave errors");

		chk_i.report_summary(fails);
		if (fails == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- build.f
+incdir+include
design/zhx_pkg.sv
design/zhx_ifs.sv
design/boot_loader.sv
design/program_ram.sv
design/cpu_core.sv
design/debug_regs.sv
design/zhx_top.sv
verification/tb_checker.sv
verification/tb_top.sv

//--- run.sh
#!/bin/sh
# Build and run the zhx subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --top-module tb_top -f build.f --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Simulation passed" sim.log; then
	echo "run.sh: pass message found"
	exit 0
else
	echo "run.sh: pass message not found"
	exit 1
fi
